// File: project.f
design/corePkg.sv
design/instrDecode.sv
design/regFile.sv
design/operandForward.sv
design/execUnit.sv
design/coreTop.sv
test/coreChecker.sv
test/coreTb.sv

// File: Makefile
# Verilator build and run of the pipeline testbench

SRCS := $(shell cat project.f)

.PHONY: run clean

run: obj_dir/VcoreTb
	./obj_dir/VcoreTb | tee sim.log
	grep -q "TEST PASSED" sim.log

obj_dir/VcoreTb: project.f $(SRCS)
	verilator --binary --timing --top-module coreTb -Mdir obj_dir -f project.f

clean:
	rm -rf obj_dir sim.log

// File: test/coreTb.sv
/*
 * Pipeline testbench
 * Drives random RV32I integer instructions into the core and leaves
 * the writeback comparison to the checker
 */
`timescale 1ns/1ps
`default_nettype none

module coreTb;

	localparam int          NUM_INSTR    = 2000;
	localparam int          RESET_CYCLES = 5;
	localparam int          CYCLE_LIMIT  = NUM_INSTR * 2 + 50;
	localparam logic [31:0] SEED         = 32'd53721;

	localparam logic [6:0] OPC_REG   = 7'b0110011;
	localparam logic [6:0] OPC_IMM   = 7'b0010011;
	localparam logic [6:0] OPC_UPPER = 7'b0110111;

	logic        clk = 1'b0;
	logic        i_rst;
	logic        i_instrValid;
	logic [31:0] i_instr;
	logic        o_wbValid;
	logic [4:0]  o_wbAddr;
	logic [31:0] o_wbData;

	logic        done;
	logic        reportDone;
	int          errorCount;
	logic [31:0] rngState = SEED;
	int          cycleCount = 0;
	int          issued;

	always #5 clk = ~clk;

	coreTop i_coreTop (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_instrValid (i_instrValid),
		.i_instr      (i_instr),
		.o_wbValid    (o_wbValid),
		.o_wbAddr     (o_wbAddr),
		.o_wbData     (o_wbData)
	);

	coreChecker wbChecker (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_instrValid (i_instrValid),
		.i_instr      (i_instr),
		.i_wbValid    (o_wbValid),
		.i_wbAddr     (o_wbAddr),
		.i_wbData     (o_wbData),
		.i_done       (done),
		.o_reportDone (reportDone),
		.o_errorCount (errorCount)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic drawRandom(output logic [31:0] value);
		rngState = xorshift32(rngState);
		value = rngState;
	endtask

	// Registers stay within x0-x7 so hazards are dense
	function automatic logic [31:0] buildInstr(input logic [31:0] r, input logic [31:0] imm);
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] immField;
		logic [6:0]  badOpc;
		rd = {2'b00, r[6:4]};
		rs1 = {2'b00, r[9:7]};
		rs2 = {2'b00, r[12:10]};
		f3 = r[15:13];
		if (r[3:0] == 4'd0) begin
			// Load, store, branch and jal are outside the kept set
			case (r[17:16])
				2'd0: badOpc = 7'b0000011;
				2'd1: badOpc = 7'b0100011;
				2'd2: badOpc = 7'b1100011;
				default: badOpc = 7'b1101111;
			endcase
			return {imm[24:0], badOpc};
		end
		if (r[20:19] == 2'd3 && r[21]) begin
			return {imm[31:12], rd, OPC_UPPER};
		end
		if (r[20] == 1'b0) begin
			f7 = (r[18] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
			return {f7, rs2, rs1, f3, rd, OPC_REG};
		end
		immField = imm[11:0];
		if (f3 == 3'd1) begin
			immField[11:5] = 7'h00;
		end else if (f3 == 3'd5) begin
			immField[11:5] = r[18] ? 7'h20 : 7'h00;
		end
		return {immField, rs1, f3, rd, OPC_IMM};
	endfunction

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		logic [31:0] r;
		logic [31:0] imm;
		i_rst = 1'b1;
		i_instrValid = 1'b0;
		i_instr = '0;
		done = 1'b0;
		issued = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		i_rst <= 1'b0;
		while (issued < NUM_INSTR) begin
			@(posedge clk);
			drawRandom(r);
			drawRandom(imm);
			// Strobe in about three of four cycles
			if (r[31:30] != 2'b00) begin
				i_instrValid <= 1'b1;
				i_instr <= buildInstr(r, imm);
				issued++;
			end else begin
				i_instrValid <= 1'b0;
				i_instr <= imm;
			end
		end
		@(posedge clk);
		i_instrValid <= 1'b0;
		// Last writeback lands two cycles after its strobe
		repeat (4) @(posedge clk);
		done <= 1'b1;
		wait (reportDone);
		@(negedge clk);
		if (errorCount == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: test/coreChecker.sv
/*
 * Writeback checker
 * Architectural register model fed by the instruction strobe, compared
 * against every writeback two cycles later
 */
`timescale 1ns/1ps
`default_nettype none

module coreChecker (
	input  logic        clk,
	input  logic        i_rst,
	input  logic        i_instrValid,
	input  logic [31:0] i_instr,
	input  logic        i_wbValid,
	input  logic [4:0]  i_wbAddr,
	input  logic [31:0] i_wbData,
	input  logic        i_done,
	output logic        o_reportDone,
	output int          o_errorCount
);

	localparam logic [6:0] OPC_REG   = 7'b0110011;
	localparam logic [6:0] OPC_IMM   = 7'b0010011;
	localparam logic [6:0] OPC_UPPER = 7'b0110111;

	logic [31:0] model [32];
	logic [4:0]  expAddr [$];
	logic [31:0] expData [$];
	int          expDue [$];
	int          cycle = 0;
	int          matched = 0;
	int          valueErrors = 0;
	int          missingErrors = 0;
	int          unexpectedErrors = 0;
	int          leftover = 0;

	assign o_errorCount = valueErrors + missingErrors + unexpectedErrors + leftover;

	initial begin
		o_reportDone = 1'b0;
		for (int i = 0; i < 32; i++) begin
			model[i] = '0;
		end
	end

	function automatic logic isSupported(input logic [31:0] instr);
		logic [2:0] f3;
		logic [6:0] f7;
		f3 = instr[14:12];
		f7 = instr[31:25];
		case (instr[6:0])
			OPC_REG: return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
			OPC_IMM: begin
				if (f3 == 3'd1) begin
					return f7 == 7'h00;
				end
				if (f3 == 3'd5) begin
					return f7 == 7'h00 || f7 == 7'h20;
				end
				return 1'b1;
			end
			OPC_UPPER: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// ISA semantics of the kept integer ops
	function automatic logic [31:0] modelResult(input logic [31:0] instr,
		input logic [31:0] a, input logic [31:0] regB);
		logic [31:0] b;
		logic [4:0]  sh;
		logic        alt;
		if (instr[6:0] == OPC_UPPER) begin
			return {instr[31:12], 12'h000};
		end
		b = (instr[6:0] == OPC_REG) ? regB : {{20{instr[31]}}, instr[31:20]};
		sh = b[4:0];
		alt = instr[30];
		case (instr[14:12])
			3'd0: return (instr[6:0] == OPC_REG && alt) ? a - b : a + b;
			3'd1: return a << sh;
			// Flipping the sign bit turns a signed compare into an unsigned one
			3'd2: return {31'b0, (a ^ 32'h80000000) < (b ^ 32'h80000000)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return (a >> sh) | ((alt && a[31]) ? ~(32'hffffffff >> sh) : 32'h0);
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic checkWriteback();
		if (expDue.size() > 0 && expDue[0] == cycle) begin
			if (!i_wbValid) begin
				$display("FAIL %0t: missing writeback strobe for x%0d", $time, expAddr[0]);
				missingErrors++;
			end else if (i_wbAddr != expAddr[0] || i_wbData != expData[0]) begin
				$display("FAIL %0t: writeback x%0d = %08h, expected x%0d = %08h",
					$time, i_wbAddr, i_wbData, expAddr[0], expData[0]);
				valueErrors++;
			end else begin
				matched++;
			end
			void'(expAddr.pop_front());
			void'(expData.pop_front());
			void'(expDue.pop_front());
		end else if (i_wbValid) begin
			$display("FAIL %0t: unexpected writeback strobe x%0d = %08h",
				$time, i_wbAddr, i_wbData);
			unexpectedErrors++;
		end
	endtask

	task automatic modelInstruction(input logic [31:0] instr);
		logic [4:0]  rd;
		logic [31:0] result;
		rd = instr[11:7];
		if (isSupported(instr) && rd != 5'd0) begin
			result = modelResult(instr, model[instr[19:15]], model[instr[24:20]]);
			model[rd] = result;
			expAddr.push_back(rd);
			expData.push_back(result);
			expDue.push_back(cycle + 2);
		end
	endtask

	always @(posedge clk) begin
		cycle = cycle + 1;
		checkWriteback();
		if (i_rst) begin
			for (int i = 0; i < 32; i++) begin
				model[i] = '0;
			end
		end else if (i_instrValid) begin
			modelInstruction(i_instr);
		end
		if (i_done && !o_reportDone) begin
			leftover = expDue.size();
			if (leftover > 0) begin
				$display("%0d expected writebacks never arrived", leftover);
			end
			$display("Checks: %0d ok, %0d wrong, %0d missing, %0d unexpected, %0d leftover",
				matched, valueErrors, missingErrors, unexpectedErrors, leftover);
			o_reportDone = 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/coreTop.sv
/*
 * Core top
 * Three-stage integer pipeline: decode, execute and writeback with
 * full operand forwarding
 */
`timescale 1ns/1ps
`default_nettype none

module coreTop (
	input  logic              clk,
	input  logic              i_rst,
	input  logic              i_instrValid,
	input  corePkg::instr_t   i_instr,
	output logic              o_wbValid,
	output corePkg::regAddr_t o_wbAddr,
	output corePkg::data_t    o_wbData
);
	import corePkg::*;

	regAddr_t rs1Addr;
	regAddr_t rs2Addr;
	data_t    rfRs1Data;
	data_t    rfRs2Data;
	data_t    fwdRs1Data;
	data_t    fwdRs2Data;

	logic     exValid;
	aluOp_e   exAluOp;
	regAddr_t exRdAddr;
	data_t    exOpA;
	data_t    exOpB;
	data_t    exResult;

	instrDecode i_instrDecode (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_instrValid (i_instrValid),
		.i_instr      (i_instr),
		.i_rs1Data    (fwdRs1Data),
		.i_rs2Data    (fwdRs2Data),
		.o_rs1Addr    (rs1Addr),
		.o_rs2Addr    (rs2Addr),
		.o_exValid    (exValid),
		.o_exAluOp    (exAluOp),
		.o_exRdAddr   (exRdAddr),
		.o_exOpA      (exOpA),
		.o_exOpB      (exOpB)
	);

	// Written from the writeback stage
	regFile i_regFile (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_rs1Addr (rs1Addr),
		.i_rs2Addr (rs2Addr),
		.o_rs1Data (rfRs1Data),
		.o_rs2Data (rfRs2Data),
		.i_wrEn    (o_wbValid),
		.i_wrAddr  (o_wbAddr),
		.i_wrData  (o_wbData)
	);

	operandForward i_operandForward (
		.i_rs1Addr   (rs1Addr),
		.i_rs2Addr   (rs2Addr),
		.i_rfRs1Data (rfRs1Data),
		.i_rfRs2Data (rfRs2Data),
		.i_exValid   (exValid),
		.i_exRdAddr  (exRdAddr),
		.i_exResult  (exResult),
		.i_wbValid   (o_wbValid),
		.i_wbAddr    (o_wbAddr),
		.i_wbData    (o_wbData),
		.o_rs1Data   (fwdRs1Data),
		.o_rs2Data   (fwdRs2Data)
	);

	execUnit i_execUnit (
		.clk        (clk),
		.i_rst      (i_rst),
		.i_exValid  (exValid),
		.i_exAluOp  (exAluOp),
		.i_exRdAddr (exRdAddr),
		.i_exOpA    (exOpA),
		.i_exOpB    (exOpB),
		.o_exResult (exResult),
		.o_wbValid  (o_wbValid),
		.o_wbAddr   (o_wbAddr),
		.o_wbData   (o_wbData)
	);

endmodule

`default_nettype wire

// File: design/execUnit.sv
/*
 * Execute unit
 * Integer ALU with its result exposed for forwarding, plus the register
 * that feeds the writeback stage
 */
`timescale 1ns/1ps
`default_nettype none

module execUnit (
	input  logic              clk,
	input  logic              i_rst,
	input  logic              i_exValid,
	input  corePkg::aluOp_e   i_exAluOp,
	input  corePkg::regAddr_t i_exRdAddr,
	input  corePkg::data_t    i_exOpA,
	input  corePkg::data_t    i_exOpB,
	output corePkg::data_t    o_exResult,
	output logic              o_wbValid,
	output corePkg::regAddr_t o_wbAddr,
	output corePkg::data_t    o_wbData
);
	import corePkg::*;

	logic [4:0] shamt;
	logic       ltSigned;
	logic       ltUnsigned;

	// Shift amount is masked to the low five bits
	assign shamt      = i_exOpB[4:0];
	assign ltSigned   = $signed(i_exOpA) < $signed(i_exOpB);
	assign ltUnsigned = i_exOpA < i_exOpB;

	always_comb begin
		case (i_exAluOp)
			ADD:    o_exResult = i_exOpA + i_exOpB;
			SUB:    o_exResult = i_exOpA - i_exOpB;
			SLL:    o_exResult = i_exOpA << shamt;
			SLT:    o_exResult = {{(DATA_WIDTH-1){1'b0}}, ltSigned};
			SLTU:   o_exResult = {{(DATA_WIDTH-1){1'b0}}, ltUnsigned};
			XOR:    o_exResult = i_exOpA ^ i_exOpB;
			SRL:    o_exResult = i_exOpA >> shamt;
			// Arithmetic shift keeps the sign bit
			SRA:    o_exResult = data_t'($signed(i_exOpA) >>> shamt);
			OR:     o_exResult = i_exOpA | i_exOpB;
			AND:    o_exResult = i_exOpA & i_exOpB;
			PASS_B: o_exResult = i_exOpB;
			default: o_exResult = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_wbValid <= 1'b0;
		end else begin
			o_wbValid <= i_exValid;
		end
	end

	// Writeback payload
	always_ff @(posedge clk) begin
		o_wbAddr <= i_exRdAddr;
		o_wbData <= o_exResult;
	end

endmodule

`default_nettype wire

// File: design/operandForward.sv
/*
 * Operand forwarding
 * Picks each source operand from execute, writeback or the register file
 */
`timescale 1ns/1ps
`default_nettype none

module operandForward (
	input  corePkg::regAddr_t i_rs1Addr,
	input  corePkg::regAddr_t i_rs2Addr,
	input  corePkg::data_t    i_rfRs1Data,
	input  corePkg::data_t    i_rfRs2Data,
	input  logic              i_exValid,
	input  corePkg::regAddr_t i_exRdAddr,
	input  corePkg::data_t    i_exResult,
	input  logic              i_wbValid,
	input  corePkg::regAddr_t i_wbAddr,
	input  corePkg::data_t    i_wbData,
	output corePkg::data_t    o_rs1Data,
	output corePkg::data_t    o_rs2Data
);
	import corePkg::*;

	// Youngest producer wins, then writeback, then the stored value
	function automatic data_t pickOperand(
		input regAddr_t srcAddr,
		input data_t    rfData,
		input logic     exValid,
		input regAddr_t exRdAddr,
		input data_t    exResult,
		input logic     wbValid,
		input regAddr_t wbAddr,
		input data_t    wbData
	);
		if (exValid && exRdAddr == srcAddr) begin
			return exResult;
		end
		if (wbValid && wbAddr == srcAddr) begin
			return wbData;
		end
		return rfData;
	endfunction

	assign o_rs1Data = pickOperand(i_rs1Addr, i_rfRs1Data, i_exValid, i_exRdAddr,
		i_exResult, i_wbValid, i_wbAddr, i_wbData);
	assign o_rs2Data = pickOperand(i_rs2Addr, i_rfRs2Data, i_exValid, i_exRdAddr,
		i_exResult, i_wbValid, i_wbAddr, i_wbData);

endmodule

`default_nettype wire

// File: design/regFile.sv
/*
 * Register file
 * Thirty-two integer registers, two combinational reads, one clocked write
 */
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  logic              clk,
	input  logic              i_rst,
	input  corePkg::regAddr_t i_rs1Addr,
	input  corePkg::regAddr_t i_rs2Addr,
	output corePkg::data_t    o_rs1Data,
	output corePkg::data_t    o_rs2Data,
	input  logic              i_wrEn,
	input  corePkg::regAddr_t i_wrAddr,
	input  corePkg::data_t    i_wrData
);
	import corePkg::*;

	data_t regs [2**RF_ADDR_WIDTH];

	// Entry 0 stays zero since decode never enables a write to x0
	always_ff @(posedge clk) begin
		if (i_rst) begin
			for (int i = 0; i < 2**RF_ADDR_WIDTH; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wrEn) begin
			regs[i_wrAddr] <= i_wrData;
		end
	end

	// Same-cycle writes are covered by the forwarding block
	assign o_rs1Data = regs[i_rs1Addr];
	assign o_rs2Data = regs[i_rs2Addr];

endmodule

`default_nettype wire

// File: design/instrDecode.sv
/*
 * Instruction decode
 * Recognises the supported RV32I ops, builds the immediate and registers
 * forwarded operands and control into the execute stage
 */
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
	input  logic              clk,
	input  logic              i_rst,
	input  logic              i_instrValid,
	input  corePkg::instr_t   i_instr,
	input  corePkg::data_t    i_rs1Data,
	input  corePkg::data_t    i_rs2Data,
	output corePkg::regAddr_t o_rs1Addr,
	output corePkg::regAddr_t o_rs2Addr,
	output logic              o_exValid,
	output corePkg::aluOp_e   o_exAluOp,
	output corePkg::regAddr_t o_exRdAddr,
	output corePkg::data_t    o_exOpA,
	output corePkg::data_t    o_exOpB
);
	import corePkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	regAddr_t   rdAddr;
	data_t      immI;
	data_t      immU;
	aluOp_e     aluOp;
	logic       supported;
	data_t      opB;

	assign opcode    = i_instr[6:0];
	assign rdAddr    = i_instr[11:7];
	assign funct3    = i_instr[14:12];
	assign funct7    = i_instr[31:25];
	assign o_rs1Addr = i_instr[19:15];
	assign o_rs2Addr = i_instr[24:20];

	assign immI = {{20{i_instr[31]}}, i_instr[31:20]};
	assign immU = {i_instr[31:12], 12'b0};

	always_comb begin
		// Register and immediate forms share the funct3 mapping
		case (funct3)
			3'b000: aluOp = (opcode == OPC_OP && funct7[5]) ? SUB : ADD;
			3'b001: aluOp = SLL;
			3'b010: aluOp = SLT;
			3'b011: aluOp = SLTU;
			3'b100: aluOp = XOR;
			3'b101: aluOp = funct7[5] ? SRA : SRL;
			3'b110: aluOp = OR;
			default: aluOp = AND;
		endcase
		supported = 1'b0;
		opB = i_rs2Data;
		case (opcode)
			OPC_OP: begin
				supported = (funct7 == 7'b0000000) ||
					(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
			end
			OPC_OP_IMM: begin
				opB = immI;
				// Shift immediates reuse the funct7 field above shamt
				if (funct3 == 3'b001) begin
					supported = (funct7 == 7'b0000000);
				end else if (funct3 == 3'b101) begin
					supported = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
				end else begin
					supported = 1'b1;
				end
			end
			OPC_LUI: begin
				aluOp = PASS_B;
				opB = immU;
				supported = 1'b1;
			end
			default: begin
				supported = 1'b0;
			end
		endcase
	end

	// Only real register writes travel down the pipe as valid
	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_exValid <= 1'b0;
		end else begin
			o_exValid <= i_instrValid && supported && (rdAddr != '0);
		end
	end

	always_ff @(posedge clk) begin
		o_exAluOp  <= aluOp;
		o_exRdAddr <= rdAddr;
		o_exOpA    <= i_rs1Data;
		o_exOpB    <= opB;
	end

endmodule

`default_nettype wire

// File: design/corePkg.sv
/*
 * Core package
 * Widths, value types, accepted opcodes and ALU operations shared by the
 * integer pipeline
 */
`default_nettype none

package corePkg;

	// Integer datapath and register index widths
	localparam int DATA_WIDTH    = 32;
	localparam int RF_ADDR_WIDTH = 5;

	typedef logic [DATA_WIDTH-1:0]    data_t;
	typedef logic [RF_ADDR_WIDTH-1:0] regAddr_t;
	typedef logic [31:0]              instr_t;

	// Major opcodes the pipeline accepts
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;

	// ALU operations selected in decode
	typedef enum logic [3:0] {
		ADD    = 4'd0,
		SUB    = 4'd1,
		SLL    = 4'd2,
		SLT    = 4'd3,
		SLTU   = 4'd4,
		XOR    = 4'd5,
		SRL    = 4'd6,
		SRA    = 4'd7,
		OR     = 4'd8,
		AND    = 4'd9,
		// LUI passes the upper immediate straight through
		PASS_B = 4'd10
	} aluOp_e;

endpackage

`default_nettype wire
